//--- src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // ************************************************************************
  // Instruction word and field types
  // ************************************************************************

  // Raw 32-bit RV32I instruction word
  typedef logic [31:0] instr_t;

  // Major opcode in bits 6:0
  typedef logic [6:0] opcode_t;

  // Minor function fields
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // Immediate fields before extension
  typedef logic [11:0] imm_i_t;
  typedef logic [19:0] imm_u_t;

  // ************************************************************************
  // Encodings
  // ************************************************************************

  // Supported major opcodes
  localparam opcode_t opc_op     = 7'b0110011;
  localparam opcode_t opc_op_imm = 7'b0010011;
  localparam opcode_t opc_lui    = 7'b0110111;

  // funct3 codes shared by OP and OP-IMM
  localparam funct3_t f3_add_sub = 3'b000;
  localparam funct3_t f3_sll     = 3'b001;
  localparam funct3_t f3_slt     = 3'b010;
  localparam funct3_t f3_sltu    = 3'b011;
  localparam funct3_t f3_xor     = 3'b100;
  localparam funct3_t f3_srl_sra = 3'b101;
  localparam funct3_t f3_or      = 3'b110;
  localparam funct3_t f3_and     = 3'b111;

  // funct7 values, alt selects sub and sra
  localparam funct7_t f7_base = 7'b0000000;
  localparam funct7_t f7_alt  = 7'b0100000;

endpackage

`default_nettype wire

//--- src/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  // ************************************************************************
  // Datapath types
  // ************************************************************************

  // Data path width
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;

  // Register index and shift amount, both 5 bits wide
  typedef logic [4:0] reg_sel_t;
  typedef logic [4:0] shamt_t;

  // ALU operations, pass_b forwards operand b for lui
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_pass_b,
    alu_sll,
    alu_srl,
    alu_sra
  } alu_op_t;

  // Decoded instruction, held stable while the instruction is in flight
  typedef struct packed {
    reg_sel_t rs1;
    reg_sel_t rs2;
    reg_sel_t rd;
    word_t    imm;
    logic     use_imm;
    alu_op_t  alu_op;
    logic     is_shift;
    logic     shift_reg;
    logic     wr_en;
  } decoded_t;

  // Controller sequence
  typedef enum logic [1:0] {
    s_idle,
    s_read,
    s_exec,
    s_write
  } exec_state_t;

endpackage

`default_nettype wire

//--- src/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile #(
  parameter int NUM_REGS = 32
) (
  input  wire                    clk,
  input  wire                    reset,
  input  wire rv_core_pkg::reg_sel_t sel_porta,
  input  wire rv_core_pkg::reg_sel_t sel_portb,
  input  wire rv_core_pkg::reg_sel_t sel_rd,
  input  wire rv_core_pkg::word_t    rd_data,
  input  wire                    write_rd,
  output rv_core_pkg::word_t         porta,
  output rv_core_pkg::word_t         portb,
  input  wire rv_core_pkg::reg_sel_t dbg_sel,
  output rv_core_pkg::word_t         dbg_data
);

  // Architectural registers, entry 0 is never read
  rv_core_pkg::word_t regs [NUM_REGS];

  // x0 and indices past the end of the file read as zero
  function automatic rv_core_pkg::word_t read_reg(input rv_core_pkg::reg_sel_t sel);
    if (sel == '0 || int'(sel) >= NUM_REGS) begin
      return '0;
    end
    return regs[sel];
  endfunction

  // Combinational read ports
  always_comb begin
    porta    = read_reg(sel_porta);
    portb    = read_reg(sel_portb);
    dbg_data = read_reg(dbg_sel);
  end

  // Single write port, writes to x0 are dropped
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_rd && sel_rd != '0 && int'(sel_rd) < NUM_REGS) begin
      regs[sel_rd] <= rd_data;
    end
  end

  // Decoder must have rejected any rd outside the file
  a_write_in_range: assert property (
    @(posedge clk) disable iff (reset)
    write_rd |-> (int'(sel_rd) < NUM_REGS)
  ) else $error("register write to index %0d beyond file size", sel_rd);

endmodule

`default_nettype wire

//--- src/rv_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decoder #(
  parameter int NUM_REGS = 32
) (
  input  wire rv_isa_pkg::instr_t instr,
  output rv_core_pkg::decoded_t   dec,
  output logic                    illegal
);

  // Instruction fields
  rv_isa_pkg::opcode_t opcode;
  rv_isa_pkg::funct3_t funct3;
  rv_isa_pkg::funct7_t funct7;
  rv_isa_pkg::imm_i_t  imm_i;
  rv_isa_pkg::imm_u_t  imm_u;
  logic                alt;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign imm_i  = instr[31:20];
  assign imm_u  = instr[31:12];
  assign alt    = (funct7 == rv_isa_pkg::f7_alt);

  // Common funct3 map for OP and OP-IMM
  function automatic rv_core_pkg::alu_op_t f3_to_op(input rv_isa_pkg::funct3_t f3,
                                                    input logic sel_alt);
    case (f3)
      rv_isa_pkg::f3_add_sub: return sel_alt ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
      rv_isa_pkg::f3_sll:     return rv_core_pkg::alu_sll;
      rv_isa_pkg::f3_slt:     return rv_core_pkg::alu_slt;
      rv_isa_pkg::f3_sltu:    return rv_core_pkg::alu_sltu;
      rv_isa_pkg::f3_xor:     return rv_core_pkg::alu_xor;
      rv_isa_pkg::f3_srl_sra: return sel_alt ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
      rv_isa_pkg::f3_or:      return rv_core_pkg::alu_or;
      default:                return rv_core_pkg::alu_and;
    endcase
  endfunction

  always_comb begin
    dec     = '0;
    illegal = 1'b0;
    dec.rd  = instr[11:7];
    case (opcode)
      rv_isa_pkg::opc_lui: begin
        // U immediate forwarded through operand b
        dec.imm     = {imm_u, 12'b0};
        dec.use_imm = 1'b1;
        dec.alu_op  = rv_core_pkg::alu_pass_b;
        dec.wr_en   = 1'b1;
      end
      rv_isa_pkg::opc_op: begin
        dec.rs1       = instr[19:15];
        dec.rs2       = instr[24:20];
        dec.alu_op    = f3_to_op(funct3, alt);
        dec.is_shift  = (funct3 == rv_isa_pkg::f3_sll) || (funct3 == rv_isa_pkg::f3_srl_sra);
        dec.shift_reg = dec.is_shift;
        dec.wr_en     = 1'b1;
        // Only add and srl have an alternate form
        if (funct7 != rv_isa_pkg::f7_base &&
            !(alt && (funct3 == rv_isa_pkg::f3_add_sub ||
                      funct3 == rv_isa_pkg::f3_srl_sra))) begin
          illegal = 1'b1;
        end
        if (int'(dec.rs2) >= NUM_REGS) begin
          illegal = 1'b1;
        end
      end
      rv_isa_pkg::opc_op_imm: begin
        // Sign-extended I immediate, shamt sits in its low bits
        dec.rs1      = instr[19:15];
        dec.imm      = {{20{imm_i[11]}}, imm_i};
        dec.use_imm  = 1'b1;
        dec.alu_op   = f3_to_op(funct3, alt && funct3 == rv_isa_pkg::f3_srl_sra);
        dec.is_shift = (funct3 == rv_isa_pkg::f3_sll) || (funct3 == rv_isa_pkg::f3_srl_sra);
        dec.wr_en    = 1'b1;
        if (funct3 == rv_isa_pkg::f3_sll && funct7 != rv_isa_pkg::f7_base) begin
          illegal = 1'b1;
        end
        if (funct3 == rv_isa_pkg::f3_srl_sra && funct7 != rv_isa_pkg::f7_base && !alt) begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase
    // Register indices past a reduced file
    if (int'(dec.rd) >= NUM_REGS || int'(dec.rs1) >= NUM_REGS) begin
      illegal = 1'b1;
    end
    if (illegal) begin
      dec.wr_en = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- src/rv_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        op_latch,
  input  wire                        shift_step,
  input  wire rv_core_pkg::decoded_t dec,
  input  wire rv_core_pkg::word_t    porta,
  input  wire rv_core_pkg::word_t    portb,
  output rv_core_pkg::word_t         result
);

  // Latched operands and the serial shift register
  rv_core_pkg::word_t op_a;
  rv_core_pkg::word_t op_b;
  rv_core_pkg::word_t shift_q;

  // ************************************************************************
  // Operand capture and bit-serial shifter
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      op_a    <= '0;
      op_b    <= '0;
      shift_q <= '0;
    end else if (op_latch) begin
      op_a    <= porta;
      op_b    <= dec.use_imm ? dec.imm : portb;
      shift_q <= porta;
    end else if (shift_step) begin
      // One bit position per step
      case (dec.alu_op)
        rv_core_pkg::alu_sll: shift_q <= {shift_q[30:0], 1'b0};
        rv_core_pkg::alu_srl: shift_q <= {1'b0, shift_q[31:1]};
        rv_core_pkg::alu_sra: shift_q <= {shift_q[31], shift_q[31:1]};
        default:              shift_q <= shift_q;
      endcase
    end
  end

  // ************************************************************************
  // Single-cycle operations
  // ************************************************************************

  always_comb begin
    case (dec.alu_op)
      rv_core_pkg::alu_add:    result = op_a + op_b;
      rv_core_pkg::alu_sub:    result = op_a - op_b;
      rv_core_pkg::alu_and:    result = op_a & op_b;
      rv_core_pkg::alu_or:     result = op_a | op_b;
      rv_core_pkg::alu_xor:    result = op_a ^ op_b;
      rv_core_pkg::alu_slt:    result = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_core_pkg::alu_sltu:   result = {31'b0, op_a < op_b};
      rv_core_pkg::alu_pass_b: result = op_b;
      // Shifts read back the serial register
      default:                 result = shift_q;
    endcase
  end

endmodule

`default_nettype wire

//--- src/rv_shift_counter.sv
`timescale 1ns/10ps
`default_nettype none

module rv_shift_counter (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      cnt_load,
  input  wire rv_core_pkg::shamt_t shamt,
  input  wire                      shift_step,
  output logic                     cnt_zero
);

  // Remaining shift steps
  rv_core_pkg::shamt_t cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (cnt_load) begin
      cnt <= shamt;
    end else if (shift_step) begin
      cnt <= cnt - 1'b1;
    end
  end

  // Tells the controller to leave exec
  assign cnt_zero = (cnt == '0);

  // Controller must stop stepping once the count runs out
  a_no_step_at_zero: assert property (
    @(posedge clk) disable iff (reset)
    shift_step |-> !cnt_zero
  ) else $error("shift step issued with a zero count");

endmodule

`default_nettype wire

//--- src/rv_exec_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec_ctrl (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        instr_valid,
  input  wire rv_core_pkg::decoded_t dec,
  input  wire                        illegal_in,
  input  wire                        cnt_zero,
  output logic                       busy,
  output logic                       done,
  output logic                       illegal,
  output logic                       op_latch,
  output logic                       cnt_load,
  output logic                       shift_step,
  output logic                       rd_write
);

  rv_core_pkg::exec_state_t state;
  rv_core_pkg::exec_state_t state_nxt;

  // ************************************************************************
  // State register
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rv_core_pkg::s_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // ************************************************************************
  // Next state and steering
  // ************************************************************************

  always_comb begin
    state_nxt  = state;
    op_latch   = 1'b0;
    cnt_load   = 1'b0;
    shift_step = 1'b0;
    rd_write   = 1'b0;
    done       = 1'b0;
    illegal    = 1'b0;
    case (state)
      rv_core_pkg::s_idle: begin
        // Busy is low here so any strobe is accepted
        if (instr_valid) begin
          state_nxt = rv_core_pkg::s_read;
        end
      end
      rv_core_pkg::s_read: begin
        if (illegal_in) begin
          // Abort with no write
          illegal   = 1'b1;
          state_nxt = rv_core_pkg::s_idle;
        end else begin
          op_latch  = 1'b1;
          cnt_load  = 1'b1;
          state_nxt = rv_core_pkg::s_exec;
        end
      end
      rv_core_pkg::s_exec: begin
        // One step per remaining bit of a shift
        if (dec.is_shift && !cnt_zero) begin
          shift_step = 1'b1;
        end else begin
          state_nxt = rv_core_pkg::s_write;
        end
      end
      default: begin
        done      = 1'b1;
        rd_write  = dec.wr_en;
        state_nxt = rv_core_pkg::s_idle;
      end
    endcase
  end

  assign busy = (state != rv_core_pkg::s_idle);

  a_done_illegal_excl: assert property (
    @(posedge clk) disable iff (reset)
    !(done && illegal)
  ) else $error("done and illegal raised together");

endmodule

`default_nettype wire

//--- src/rv_exec_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec_top #(
  parameter int NUM_REGS = 32
) (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        instr_valid,
  input  wire rv_isa_pkg::instr_t    instr,
  output logic                       busy,
  output logic                       done,
  output logic                       illegal,
  input  wire rv_core_pkg::reg_sel_t dbg_sel,
  output rv_core_pkg::word_t         dbg_data
);

  // Instruction register and decode results
  rv_isa_pkg::instr_t    instr_q;
  rv_core_pkg::decoded_t dec;
  logic                  dec_illegal;

  // Datapath
  rv_core_pkg::word_t  porta;
  rv_core_pkg::word_t  portb;
  rv_core_pkg::word_t  result;
  rv_core_pkg::shamt_t shamt;

  // Steering from the controller
  logic op_latch;
  logic cnt_load;
  logic shift_step;
  logic rd_write;
  logic cnt_zero;

  // Capture on an accepted strobe only
  always_ff @(posedge clk) begin
    if (instr_valid && !busy) begin
      instr_q <= instr;
    end
  end

  // Register shifts take rs2, immediate shifts the shamt field
  assign shamt = dec.shift_reg ? portb[4:0] : dec.imm[4:0];

  rv_decoder #(.NUM_REGS(NUM_REGS)) u_decoder (
    .instr   (instr_q),
    .dec     (dec),
    .illegal (dec_illegal)
  );

  rv_regfile #(.NUM_REGS(NUM_REGS)) u_regfile (
    .clk       (clk),
    .reset     (reset),
    .sel_porta (dec.rs1),
    .sel_portb (dec.rs2),
    .sel_rd    (dec.rd),
    .rd_data   (result),
    .write_rd  (rd_write),
    .porta     (porta),
    .portb     (portb),
    .dbg_sel   (dbg_sel),
    .dbg_data  (dbg_data)
  );

  rv_alu u_alu (
    .clk        (clk),
    .reset      (reset),
    .op_latch   (op_latch),
    .shift_step (shift_step),
    .dec        (dec),
    .porta      (porta),
    .portb      (portb),
    .result     (result)
  );

  rv_shift_counter u_shift_counter (
    .clk        (clk),
    .reset      (reset),
    .cnt_load   (cnt_load),
    .shamt      (shamt),
    .shift_step (shift_step),
    .cnt_zero   (cnt_zero)
  );

  rv_exec_ctrl u_exec_ctrl (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .dec         (dec),
    .illegal_in  (dec_illegal),
    .cnt_zero    (cnt_zero),
    .busy        (busy),
    .done        (done),
    .illegal     (illegal),
    .op_latch    (op_latch),
    .cnt_load    (cnt_load),
    .shift_step  (shift_step),
    .rd_write    (rd_write)
  );

endmodule

`default_nettype wire

//--- tests/rv_exec_tasks.svh
`ifndef RV_EXEC_TASKS_SVH
`define RV_EXEC_TASKS_SVH

  // ************************************************************************
  // Encodings and instruction builders
  // ************************************************************************

  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_lui = 7'b0110111;

  localparam logic [2:0] f3_add  = 3'd0;
  localparam logic [2:0] f3_sll  = 3'd1;
  localparam logic [2:0] f3_slt  = 3'd2;
  localparam logic [2:0] f3_sltu = 3'd3;
  localparam logic [2:0] f3_xor  = 3'd4;
  localparam logic [2:0] f3_sr   = 3'd5;
  localparam logic [2:0] f3_or   = 3'd6;
  localparam logic [2:0] f3_and  = 3'd7;

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, op_imm};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] upper, input logic [4:0] rd);
    return {upper, rd, op_lui};
  endfunction

  // ************************************************************************
  // Reference model, RV32I semantics
  // ************************************************************************

  function automatic bit model_legal(input logic [31:0] w);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = w[14:12];
    f7 = w[31:25];
    case (w[6:0])
      op_lui: return 1'b1;
      // Only add and srl have an alternate form
      op_reg: return f7 == 7'h00 || (f7 == 7'h20 && (f3 == f3_add || f3 == f3_sr));
      op_imm: begin
        if (f3 == f3_sll) begin
          return f7 == 7'h00;
        end
        if (f3 == f3_sr) begin
          return f7 == 7'h00 || f7 == 7'h20;
        end
        return 1'b1;
      end
      default: return 1'b0;
    endcase
  endfunction

  // Shift amount for shifts, zero for everything else
  function automatic int model_shamt(input logic [31:0] w);
    if ((w[6:0] != op_reg && w[6:0] != op_imm) ||
        (w[14:12] != f3_sll && w[14:12] != f3_sr)) begin
      return 0;
    end
    return (w[6:0] == op_reg) ? int'(model_regs[w[24:20]][4:0]) : int'(w[24:20]);
  endfunction

  function automatic logic [31:0] model_result(input logic [31:0] w);
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    a  = model_regs[w[19:15]];
    b  = (w[6:0] == op_reg) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
    sh = b[4:0];
    if (w[6:0] == op_lui) begin
      return {w[31:12], 12'b0};
    end
    case (w[14:12])
      // funct7 bit 30 only means sub for register ops
      f3_add:  return (w[6:0] == op_reg && w[30]) ? a - b : a + b;
      f3_sll:  return a << sh;
      f3_slt:  return {31'b0, $signed(a) < $signed(b)};
      f3_sltu: return {31'b0, a < b};
      f3_xor:  return a ^ b;
      f3_sr:   return w[30] ? 32'($signed(a) >>> sh) : a >> sh;
      f3_or:   return a | b;
      default: return a & b;
    endcase
  endfunction

  // ************************************************************************
  // Failure reporting and checks
  // ************************************************************************

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED: %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  // Debug port is combinational, sampled mid-cycle
  task automatic read_dbg(input logic [4:0] sel, output logic [31:0] value);
    @(posedge clk);
    dbg_sel <= sel;
    @(negedge clk);
    value = dbg_data;
  endtask

  task automatic check_all_regs();
    logic [31:0] value;
    for (int i = 0; i < 32; i++) begin
      read_dbg(5'(i), value);
      check_eq($sformatf("dbg_data x%0d", i), value, model_regs[i]);
    end
  endtask

  // Issues one instruction, waits for done or illegal, checks latency and rd
  task automatic run_instr(input logic [31:0] w, input bit inject);
    bit          legal;
    bit          seen;
    logic [31:0] expected;
    logic [31:0] value;
    logic [4:0]  rd;
    int          exp_cycles;
    int          cycles;
    legal      = model_legal(w);
    expected   = model_result(w);
    exp_cycles = legal ? 3 + model_shamt(w) : 1;
    rd         = w[11:7];
    cycles     = 0;
    seen       = 1'b0;
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= w;
    // Accept edge
    @(posedge clk);
    instr_valid <= 1'b0;
    while (!seen) begin
      @(negedge clk);
      cycles++;
      check_eq("busy", busy, 1'b1);
      if (done || illegal) begin
        seen = 1'b1;
      end else if (cycles >= max_instr_cycles) begin
        abort_run($sformatf("No done or illegal within %0d cycles of accept", cycles));
      end else begin
        @(posedge clk);
        // Second strobe while busy, the unit must drop it
        if (inject && cycles == 1) begin
          instr_valid <= 1'b1;
          instr       <= enc_i(12'h123, 5'd0, f3_add, rd);
        end else begin
          instr_valid <= 1'b0;
        end
      end
    end
    check_eq("done", done, legal);
    check_eq("illegal", illegal, !legal);
    check_eq("latency", cycles, exp_cycles);
    if (legal && rd != 5'd0) begin
      model_regs[rd] = expected;
    end
    // Write lands on this edge
    @(posedge clk);
    @(negedge clk);
    check_eq("busy", busy, 1'b0);
    check_eq("done", done, 1'b0);
    read_dbg(rd, value);
    check_eq($sformatf("dbg_data x%0d", rd), value, model_regs[rd]);
  endtask

  // ************************************************************************
  // Directed tests
  // ************************************************************************

  task automatic test_reset();
    check_eq("busy", busy, 1'b0);
    check_eq("done", done, 1'b0);
    check_eq("illegal", illegal, 1'b0);
    check_all_regs();
  endtask

  // Sign and unsigned edges of the 12-bit immediate
  task automatic test_imm_ops();
    run_instr(enc_u(20'h80000, 5'd1), 1'b0);
    run_instr(enc_u(20'hfffff, 5'd2), 1'b0);
    run_instr(enc_i(12'hfff, 5'd0, f3_add, 5'd3), 1'b0);
    run_instr(enc_i(12'h7ff, 5'd3, f3_add, 5'd4), 1'b0);
    run_instr(enc_i(12'h800, 5'd1, f3_add, 5'd5), 1'b0);
    run_instr(enc_i(12'h0f0, 5'd2, f3_and, 5'd6), 1'b0);
    run_instr(enc_i(12'h800, 5'd0, f3_or, 5'd7), 1'b0);
    run_instr(enc_i(12'h555, 5'd3, f3_xor, 5'd8), 1'b0);
    run_instr(enc_i(12'h000, 5'd3, f3_slt, 5'd9), 1'b0);
    run_instr(enc_i(12'hfff, 5'd0, f3_slt, 5'd10), 1'b0);
    run_instr(enc_i(12'hfff, 5'd3, f3_sltu, 5'd11), 1'b0);
    run_instr(enc_i(12'hfff, 5'd0, f3_sltu, 5'd12), 1'b0);
    run_instr(enc_i(12'h001, 5'd0, f3_sltu, 5'd13), 1'b0);
  endtask

  // x0 as a source, and a write to x0 that must vanish
  task automatic test_reg_ops();
    run_instr(enc_r(7'h00, 5'd4, 5'd1, f3_add, 5'd14), 1'b0);
    run_instr(enc_r(7'h20, 5'd3, 5'd0, f3_add, 5'd15), 1'b0);
    run_instr(enc_r(7'h00, 5'd7, 5'd2, f3_and, 5'd16), 1'b0);
    run_instr(enc_r(7'h00, 5'd0, 5'd1, f3_or, 5'd17), 1'b0);
    run_instr(enc_r(7'h00, 5'd4, 5'd3, f3_xor, 5'd18), 1'b0);
    run_instr(enc_r(7'h00, 5'd0, 5'd1, f3_slt, 5'd19), 1'b0);
    run_instr(enc_r(7'h00, 5'd0, 5'd1, f3_sltu, 5'd20), 1'b0);
    run_instr(enc_r(7'h00, 5'd1, 5'd0, f3_slt, 5'd21), 1'b0);
    run_instr(enc_r(7'h00, 5'd3, 5'd0, f3_sltu, 5'd22), 1'b0);
    run_instr(enc_r(7'h00, 5'd3, 5'd3, f3_add, 5'd0), 1'b0);
  endtask

  task automatic test_shifts();
    logic [4:0] amt_list [4];
    amt_list = '{5'd0, 5'd1, 5'd17, 5'd31};
    // Negative and positive sources
    run_instr(enc_u(20'h9abcd, 5'd24), 1'b0);
    run_instr(enc_i(12'h0ef, 5'd24, f3_xor, 5'd24), 1'b0);
    run_instr(enc_u(20'h12345, 5'd23), 1'b0);
    run_instr(enc_i(12'h678, 5'd23, f3_or, 5'd23), 1'b0);
    foreach (amt_list[k]) begin
      // Bit 5 set in rs2, only the low five bits count
      run_instr(enc_i({7'b0000001, amt_list[k]}, 5'd0, f3_add, 5'd25), 1'b0);
      run_instr(enc_r(7'h00, 5'd25, 5'd24, f3_sll, 5'd26), 1'b0);
      run_instr(enc_r(7'h00, 5'd25, 5'd24, f3_sr, 5'd27), 1'b1);
      run_instr(enc_r(7'h20, 5'd25, 5'd24, f3_sr, 5'd28), 1'b1);
      run_instr(enc_i({7'h00, amt_list[k]}, 5'd23, f3_sll, 5'd29), 1'b0);
      run_instr(enc_i({7'h00, amt_list[k]}, 5'd24, f3_sr, 5'd30), 1'b1);
      run_instr(enc_i({7'h20, amt_list[k]}, 5'd24, f3_sr, 5'd31), 1'b0);
    end
  endtask

  // Bad opcodes and funct7 values, each aimed at a live rd
  task automatic test_illegal();
    logic [31:0] words [7];
    words = '{
      {25'h0001283, 7'b0000011},
      {25'h0000283, 7'b1101111},
      32'h0000_0000,
      enc_r(7'h01, 5'd4, 5'd3, f3_add, 5'd5),
      enc_r(7'h20, 5'd4, 5'd3, f3_and, 5'd5),
      enc_i({7'h20, 5'd3}, 5'd3, f3_sll, 5'd5),
      enc_i({7'h10, 5'd3}, 5'd3, f3_sr, 5'd5)
    };
    foreach (words[k]) begin
      run_instr(words[k], 1'b0);
      repeat (4) begin
        @(negedge clk);
        check_eq("done", done, 1'b0);
        check_eq("illegal", illegal, 1'b0);
        check_eq("busy", busy, 1'b0);
      end
      check_all_regs();
    end
  endtask

  // Supported instructions with random fields
  task automatic test_random();
    int          kind;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [31:0] w;
    for (int n = 0; n < random_instrs; n++) begin
      kind = $urandom_range(2, 0);
      f3   = 3'($urandom_range(7, 0));
      rd   = 5'($urandom_range(31, 0));
      rs1  = 5'($urandom_range(31, 0));
      rs2  = 5'($urandom_range(31, 0));
      imm  = 12'($urandom);
      if (kind == 0) begin
        f7 = ((f3 == f3_add || f3 == f3_sr) && $urandom_range(1, 0) == 1) ? 7'h20 : 7'h00;
        w  = enc_r(f7, rs2, rs1, f3, rd);
      end else if (kind == 1) begin
        // Upper immediate bits must form a valid funct7 for shifts
        if (f3 == f3_sll) begin
          imm[11:5] = 7'h00;
        end else if (f3 == f3_sr) begin
          imm[11:5] = ($urandom_range(1, 0) == 1) ? 7'h20 : 7'h00;
        end
        w = enc_i(imm, rs1, f3, rd);
      end else begin
        w = enc_u(20'($urandom), rd);
      end
      run_instr(w, 1'b0);
    end
    check_all_regs();
  endtask

`endif

//--- tests/rv_exec_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec_tb;

  // ************************************************************************
  // Run length budget in clock cycles
  // ************************************************************************

  localparam int reset_cycles     = 16;
  localparam int max_instr_cycles = 40;
  localparam int directed_instrs  = 80;
  localparam int random_instrs    = 200;
  // Debug port sweeps over the whole file
  localparam int sweep_cycles     = 12 * 32;
  localparam int timeout_cycles   = reset_cycles + sweep_cycles
                                    + (directed_instrs + random_instrs) * max_instr_cycles;

  // DUT ports
  logic        clk;
  logic        reset;
  logic        instr_valid;
  logic [31:0] instr;
  logic        busy;
  logic        done;
  logic        illegal;
  logic [4:0]  dbg_sel;
  logic [31:0] dbg_data;

  // Reference copy of the register file where x0 is never written
  logic [31:0] model_regs [32];

  // Watchdog count
  int          cycle_count = 0;

  rv_exec_top #(.NUM_REGS(32)) rv_exec_top_inst (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .busy        (busy),
    .done        (done),
    .illegal     (illegal),
    .dbg_sel     (dbg_sel),
    .dbg_data    (dbg_data)
  );

  `include "rv_exec_tasks.svh"

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Ends a run that stalls anywhere in the sequence
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      abort_run($sformatf("Timeout after %0d cycles, test sequence did not finish",
                          cycle_count));
    end
  end

  // ************************************************************************
  // Test sequence
  // ************************************************************************

  initial begin
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    dbg_sel     = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    // One seed for the whole run
    void'($urandom(32'hbc14_4953));

    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);

    test_reset();
    test_imm_ops();
    test_reg_ops();
    test_shifts();
    test_illegal();
    test_random();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
src/rv_isa_pkg.sv
src/rv_core_pkg.sv
src/rv_regfile.sv
src/rv_decoder.sv
src/rv_alu.sv
src/rv_shift_counter.sv
src/rv_exec_ctrl.sv
src/rv_exec_top.sv
+incdir+tests
tests/rv_exec_tb.sv

//--- Bender.yml
package:
  name: rv_exec

sources:
  # Packages first, then the design in dependency order
  - src/rv_isa_pkg.sv
  - src/rv_core_pkg.sv
  - src/rv_regfile.sv
  - src/rv_decoder.sv
  - src/rv_alu.sv
  - src/rv_shift_counter.sv
  - src/rv_exec_ctrl.sv
  - src/rv_exec_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/rv_exec_tb.sv
